/* compile.f */
src/dcache_pkg.sv
src/dcache_array_if.sv
src/dcache_ways.sv
src/dcache_victim.sv
src/dcache_wb_buf.sv
src/dcache_ctrl.sv
src/dcache_top.sv
test/tb_mem_model.sv
test/tb_dcache.sv

/* test/tb_dcache.sv */
module tb_dcache;
  import dcache_pkg::*;

  localparam int timeout_cycles = 400;

  logic                   clk = 1'b0;
  logic                   rst;
  logic [31:0]            rnd = 32'h9ee9;  // stall bits that change every clock
  logic [31:0]            seq = 32'h9ee9;  // stimulus stream
  logic                   req_valid;
  logic                   req_wr;
  logic [addr_w-1:0]      req_addr;
  logic [data_w-1:0]      req_wdata;
  logic [strb_w-1:0]      req_wstrb;
  logic                   req_ready;
  logic                   rsp_valid;
  logic [data_w-1:0]      rsp_data;
  logic                   rsp_ready;
  logic                   rd_req_valid;
  logic [addr_w-1:0]      rd_req_addr;
  logic [burst_len_w-1:0] rd_req_len;
  logic                   rd_req_ready;
  logic                   rd_rsp_valid;
  logic [data_w-1:0]      rd_rsp_data;
  logic                   rd_rsp_last;
  logic                   rd_rsp_ready;
  logic                   wr_req_valid;
  logic [addr_w-1:0]      wr_req_addr;
  logic [burst_len_w-1:0] wr_req_len;
  logic                   wr_req_ready;
  logic                   wr_data_valid;
  logic [data_w-1:0]      wr_data;
  logic [strb_w-1:0]      wr_data_strb;
  logic                   wr_data_last;
  logic                   wr_data_ready;

  logic [31:0] ref_mem [logic [29:0]];  // cpu view of memory by word address
  logic [31:0] lru_q [$];               // cached line addresses with the least recent first
  bit          dirty_line [logic [31:0]];

  dcache_top uut (.*);
  tb_mem_model mem_model (.*);

  always #4 clk = ~clk;
  always @(posedge clk) rnd <= xorshift(rnd);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] d,
                                              input logic [3:0] s);
    logic [31:0] w;
    w = old;
    for (int b = 0; b < 4; b++) begin
      if (s[b]) w[b*8 +: 8] = d[b*8 +: 8];
    end
    return w;
  endfunction

  function automatic logic [31:0] expect_word(input logic [31:0] a);
    return ref_mem.exists(a[31:2]) ? ref_mem[a[31:2]] : mem_model.fill_word(a[31:2]);
  endfunction

  // first line of memory and anything with bit 31 or 30 set is uncached
  function automatic logic is_bypass(input logic [31:0] a);
    return (a < 32) || (a[31:30] != 2'b00);
  endfunction

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
      stop_run();
    end
  endtask

  // lru bookkeeping that returns the dirty line a miss must write back
  task automatic predict_lru(input logic [31:0] line, input logic wr, output logic hit,
                             output logic wb, output logic [31:0] wb_addr);
    int pos;
    int oldest;
    int cnt;
    pos = -1;
    oldest = -1;
    cnt = 0;
    hit = 1'b0;
    wb = 1'b0;
    wb_addr = '0;
    foreach (lru_q[i]) begin
      if (lru_q[i] == line) pos = i;
      if (lru_q[i][7:5] == line[7:5]) begin  // same set
        cnt++;
        if (oldest < 0) oldest = i;
      end
    end
    if (pos >= 0) begin
      hit = 1'b1;
      lru_q.delete(pos);
    end else if (cnt == num_ways) begin
      wb_addr = lru_q[oldest];  // least recent line leaves a full set
      wb = dirty_line.exists(wb_addr);
      if (wb) dirty_line.delete(wb_addr);
      lru_q.delete(oldest);
    end
    lru_q.push_back(line);
    if (wr) dirty_line[line] = 1'b1;
  endtask

  // one cpu request with random response stalls and hold checks
  task automatic bus_access(input string name, input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] strb,
                            output logic [31:0] rdata);
    int          cycles;
    logic        done;
    logic        held;
    logic [31:0] held_data;
    cycles = 0;
    done = 1'b0;
    held = 1'b0;
    held_data = '0;
    rdata = '0;
    @(negedge clk);
    req_valid = 1'b1;
    req_wr    = wr;
    req_addr  = addr;
    req_wdata = wdata;
    req_wstrb = strb;
    while (!done) begin
      rsp_ready = rnd[4];
      #2;  // let the outputs settle after the falling edge
      if (rd_rsp_ready) begin
        check_value({name, " rd_rsp_ready outside a read burst"}, 1, mem_model.rd_busy);
      end
      if (held) begin
        check_value({name, " held rsp_valid"}, 1, rsp_valid);
        check_value({name, " held rsp_data"}, held_data, rsp_data);
      end
      held = rsp_valid && !rsp_ready;
      held_data = rsp_data;
      if (held) check_value({name, " req_ready under stall"}, 0, req_ready);
      if (req_ready) begin
        done = 1'b1;
        if (!wr) check_value({name, " rsp handshake"}, 1, rsp_valid && rsp_ready);
        rdata = rsp_data;
      end
      @(negedge clk);
      cycles++;
      assert (done || cycles <= timeout_cycles) else begin
        $display("ERROR %s: req_ready did not come within %0d cycles", name, timeout_cycles);
        stop_run();
      end
    end
    req_valid = 1'b0;
    rsp_ready = 1'b0;
  endtask

  // request and then compare data and memory traffic with the model
  task automatic run_access(input string name, input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] strb);
    int          rd0;
    int          wr0;
    int          bt0;
    logic        hit;
    logic        wb;
    logic        byp;
    logic [31:0] wb_addr;
    logic [31:0] line;
    logic [31:0] rdata;
    rd0 = mem_model.rd_req_q.size();
    wr0 = mem_model.wr_req_q.size();
    bt0 = mem_model.wr_beat_q.size();
    line = {addr[31:5], 5'b0};
    byp = is_bypass(addr);
    hit = 1'b0;
    wb = 1'b0;
    wb_addr = '0;
    if (!byp) predict_lru(line, wr, hit, wb, wb_addr);
    bus_access(name, wr, addr, wdata, strb, rdata);
    if (byp) begin
      check_value({name, " read requests"}, !wr, mem_model.rd_req_q.size() - rd0);
      check_value({name, " write requests"}, wr, mem_model.wr_req_q.size() - wr0);
      check_value({name, " write beats"}, wr, mem_model.wr_beat_q.size() - bt0);
      if (wr) begin
        check_value({name, " write request"}, {8'd0, addr}, mem_model.wr_req_q[wr0]);
        check_value({name, " write beat"}, {1'b1, strb, wdata}, mem_model.wr_beat_q[bt0]);
      end else begin
        check_value({name, " read request"}, {8'd0, addr}, mem_model.rd_req_q[rd0]);
      end
    end else begin
      check_value({name, " read requests"}, !hit, mem_model.rd_req_q.size() - rd0);
      check_value({name, " write requests"}, wb, mem_model.wr_req_q.size() - wr0);
      check_value({name, " write beats"}, wb ? 8 : 0, mem_model.wr_beat_q.size() - bt0);
      if (!hit) check_value({name, " refill request"}, {8'd7, line}, mem_model.rd_req_q[rd0]);
      if (wb) begin
        check_value({name, " write-back request"}, {8'd7, wb_addr}, mem_model.wr_req_q[wr0]);
        for (int j = 0; j < 8; j++) begin
          check_value({name, " write-back beat"},
                      {j == 7, 4'hf, expect_word(wb_addr + 4 * j)},
                      mem_model.wr_beat_q[bt0 + j]);
        end
      end
    end
    if (wr) ref_mem[addr[31:2]] = merge_bytes(expect_word(addr), wdata, strb);
    else check_value({name, " read data"}, expect_word(addr), rdata);
  endtask

  initial begin
    logic [31:0] a;
    int          wr_before;
    rst       = 1'b1;
    req_valid = 1'b0;
    req_wr    = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_wstrb = '0;
    rsp_ready = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    run_access("cached_read", 0, 32'h0000_1044, '0, '0);  // miss with a line refill
    run_access("cached_read_same_line", 0, 32'h0000_1058, '0, '0);

    // two lines of set 3 with random word and strobe
    for (int k = 0; k < 12; k++) begin
      seq = xorshift(seq);
      a = 32'h0000_2060 + {seq[0], 10'b0} + {seq[3:1], 2'b0};
      run_access("strobed_write", 1, a, xorshift(seq), seq[7:4]);
      run_access("strobed_read_back", 0, a, '0, '0);
    end

    // seven tags in set 5 overflow the six ways
    wr_before = mem_model.wr_req_q.size();
    for (int k = 0; k < 7; k++) begin
      seq = xorshift(seq);
      run_access("write_back_fill", 1, 32'h0001_00a4 + k * 32'h100, seq, 4'hf);
    end
    for (int k = 0; k < 7; k++) begin
      run_access("write_back_read", 0, 32'h0001_00a4 + k * 32'h100, '0, '0);
    end
    check_value("write_back burst count", 7, mem_model.wr_req_q.size() - wr_before);

    run_access("bypass_read", 0, 32'h0000_0014, '0, '0);
    run_access("bypass_read_again", 0, 32'h0000_0014, '0, '0);
    run_access("bypass_write", 1, 32'h0000_0018, 32'ha5c3_0f96, 4'b0101);
    run_access("bypass_read_back", 0, 32'h0000_0018, '0, '0);
    seq = xorshift(seq);
    run_access("io_write", 1, 32'hc000_0104, seq, seq[11:8]);
    run_access("io_read", 0, 32'hc000_0104, '0, '0);
    run_access("io_read_bit30", 0, 32'h4000_0200, '0, '0);

    $display("PASS: all tests");
    $finish;
  end

endmodule

/* test/tb_mem_model.sv */
module tb_mem_model (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] rnd,            // stall bits, stable at the falling edge
  input  logic        rd_req_valid,
  input  logic [31:0] rd_req_addr,
  input  logic [7:0]  rd_req_len,
  output logic        rd_req_ready,
  output logic        rd_rsp_valid,
  output logic [31:0] rd_rsp_data,
  output logic        rd_rsp_last,
  input  logic        rd_rsp_ready,
  input  logic        wr_req_valid,
  input  logic [31:0] wr_req_addr,
  input  logic [7:0]  wr_req_len,
  output logic        wr_req_ready,
  input  logic        wr_data_valid,
  input  logic [31:0] wr_data,
  input  logic [3:0]  wr_data_strb,
  input  logic        wr_data_last,
  output logic        wr_data_ready
);

  logic [31:0] mem [logic [29:0]];  // written words only, word address
  logic [39:0] rd_req_q [$];        // {len, addr} of each accepted read request
  logic [39:0] wr_req_q [$];        // {len, addr} of each accepted write request
  logic [36:0] wr_beat_q [$];       // {last, strb, data} of each accepted write beat

  logic        rd_busy;
  logic        rd_pend;             // current read beat is on the bus
  logic [31:0] rd_addr;
  logic [7:0]  rd_left;             // beats after the current one
  logic        wr_busy;
  logic [31:0] wr_addr;

  // untouched words hold a pattern of their whole address
  function automatic logic [31:0] fill_word(input logic [29:0] wa);
    return {wa[13:0], wa[29:12]} ^ 32'h6b3d_c2a5;
  endfunction

  function automatic logic [31:0] read_word(input logic [29:0] wa);
    return mem.exists(wa) ? mem[wa] : fill_word(wa);
  endfunction

  task automatic store_word(input logic [29:0] wa, input logic [31:0] d, input logic [3:0] s);
    logic [31:0] w;
    w = read_word(wa);
    for (int b = 0; b < 4; b++) begin
      if (s[b]) w[b*8 +: 8] = d[b*8 +: 8];  // strobed bytes only
    end
    mem[wa] = w;
  endtask

  initial begin
    rd_req_ready  = 1'b0;
    rd_rsp_valid  = 1'b0;
    rd_rsp_data   = '0;
    rd_rsp_last   = 1'b0;
    wr_req_ready  = 1'b0;
    wr_data_ready = 1'b0;
  end

  // handshakes are taken at the rising edge
  always @(posedge clk) begin
    if (rst) begin
      rd_busy = 1'b0;
      rd_pend = 1'b0;
      rd_addr = '0;
      rd_left = '0;
      wr_busy = 1'b0;
      wr_addr = '0;
    end else begin
      if (rd_rsp_valid && rd_rsp_ready) begin
        rd_pend = 1'b0;
        rd_busy = rd_left != 0;  // burst ends with the last beat
        rd_addr = rd_addr + 4;
        rd_left = rd_left - 1'b1;
      end
      if (rd_req_valid && rd_req_ready) begin
        rd_req_q.push_back({rd_req_len, rd_req_addr});
        rd_busy = 1'b1;
        rd_addr = rd_req_addr;
        rd_left = rd_req_len;
      end
      if (wr_req_valid && wr_req_ready) begin
        wr_req_q.push_back({wr_req_len, wr_req_addr});
        wr_busy = 1'b1;
        wr_addr = wr_req_addr;
      end
      if (wr_data_valid && wr_data_ready) begin
        wr_beat_q.push_back({wr_data_last, wr_data_strb, wr_data});
        store_word(wr_addr[31:2], wr_data, wr_data_strb);
        wr_addr = wr_addr + 4;
        wr_busy = !wr_data_last;
      end
    end
  end

  // outputs change at the falling edge, with random stalls
  always @(negedge clk) begin
    if (rst) begin
      rd_req_ready  <= 1'b0;
      rd_rsp_valid  <= 1'b0;
      rd_rsp_last   <= 1'b0;
      wr_req_ready  <= 1'b0;
      wr_data_ready <= 1'b0;
    end else begin
      if (rd_busy && !rd_pend && rnd[1]) rd_pend = 1'b1;  // a raised beat stays until taken
      rd_req_ready  <= !rd_busy && rnd[0];
      rd_rsp_valid  <= rd_pend;
      rd_rsp_data   <= read_word(rd_addr[31:2]);
      rd_rsp_last   <= rd_left == 0;
      wr_req_ready  <= !wr_busy && rnd[2];
      wr_data_ready <= wr_busy && rnd[3];
    end
  end

endmodule

/* src/dcache_top.sv */
module dcache_top (
  input  logic                               clk,
  input  logic                               rst,
  // cpu request and response
  input  logic                               req_valid,
  input  logic                               req_wr,      // 1 write, 0 read
  input  logic [dcache_pkg::addr_w-1:0]      req_addr,
  input  logic [dcache_pkg::data_w-1:0]      req_wdata,
  input  logic [dcache_pkg::strb_w-1:0]      req_wstrb,
  output logic                               req_ready,
  output logic                               rsp_valid,
  output logic [dcache_pkg::data_w-1:0]      rsp_data,
  input  logic                               rsp_ready,
  // memory read burst
  output logic                               rd_req_valid,
  output logic [dcache_pkg::addr_w-1:0]      rd_req_addr,
  output logic [dcache_pkg::burst_len_w-1:0] rd_req_len,
  input  logic                               rd_req_ready,
  input  logic                               rd_rsp_valid,
  input  logic [dcache_pkg::data_w-1:0]      rd_rsp_data,
  input  logic                               rd_rsp_last,
  output logic                               rd_rsp_ready,
  // memory write burst
  output logic                               wr_req_valid,
  output logic [dcache_pkg::addr_w-1:0]      wr_req_addr,
  output logic [dcache_pkg::burst_len_w-1:0] wr_req_len,
  input  logic                               wr_req_ready,
  output logic                               wr_data_valid,
  output logic [dcache_pkg::data_w-1:0]      wr_data,
  output logic [dcache_pkg::strb_w-1:0]      wr_data_strb,
  output logic                               wr_data_last,
  input  logic                               wr_data_ready
);
  import dcache_pkg::*;

  logic              wb_load;
  logic              wb_single;
  logic [data_w-1:0] wb_word;
  logic [strb_w-1:0] wb_strb;
  logic              wb_done;

  dcache_array_if arr ();

  dcache_ctrl u_ctrl (
    .clk, .rst,
    .req_valid, .req_wr, .req_addr, .req_wdata, .req_wstrb, .req_ready,
    .rsp_valid, .rsp_data, .rsp_ready,
    .rd_req_valid, .rd_req_addr, .rd_req_len, .rd_req_ready,
    .rd_rsp_valid, .rd_rsp_data, .rd_rsp_last, .rd_rsp_ready,
    .wr_req_valid, .wr_req_addr, .wr_req_len, .wr_req_ready,
    .arr (arr),
    .wb_load, .wb_single, .wb_word, .wb_strb, .wb_done
  );

  dcache_ways u_ways (.clk, .rst, .arr (arr));

  dcache_victim u_victim (.clk, .rst, .arr (arr));

  dcache_wb_buf u_wb_buf (
    .clk, .rst,
    .load   (wb_load),
    .line   (arr.victim_line),  // captured at load
    .single (wb_single),
    .word   (wb_word),
    .strb   (wb_strb),
    .wr_data_valid, .wr_data, .wr_data_strb, .wr_data_last, .wr_data_ready,
    .done   (wb_done)
  );

endmodule

/* src/dcache_ctrl.sv */
module dcache_ctrl (
  input  logic                               clk,
  input  logic                               rst,
  // cpu side
  input  logic                               req_valid,
  input  logic                               req_wr,
  input  logic [dcache_pkg::addr_w-1:0]      req_addr,
  input  logic [dcache_pkg::data_w-1:0]      req_wdata,
  input  logic [dcache_pkg::strb_w-1:0]      req_wstrb,
  output logic                               req_ready,
  output logic                               rsp_valid,
  output logic [dcache_pkg::data_w-1:0]      rsp_data,
  input  logic                               rsp_ready,
  // memory read
  output logic                               rd_req_valid,
  output logic [dcache_pkg::addr_w-1:0]      rd_req_addr,
  output logic [dcache_pkg::burst_len_w-1:0] rd_req_len,
  input  logic                               rd_req_ready,
  input  logic                               rd_rsp_valid,
  input  logic [dcache_pkg::data_w-1:0]      rd_rsp_data,
  input  logic                               rd_rsp_last,
  output logic                               rd_rsp_ready,
  // memory write request, data goes through wb_buf
  output logic                               wr_req_valid,
  output logic [dcache_pkg::addr_w-1:0]      wr_req_addr,
  output logic [dcache_pkg::burst_len_w-1:0] wr_req_len,
  input  logic                               wr_req_ready,
  dcache_array_if.ctrl                       arr,
  output logic                               wb_load,
  output logic                               wb_single,
  output logic [dcache_pkg::data_w-1:0]      wb_word,
  output logic [dcache_pkg::strb_w-1:0]      wb_strb,
  input  logic                               wb_done
);
  import dcache_pkg::*;

  logic [state_w-1:0] state_q, state_d;
  logic               byp_q;       // current read is uncached
  logic [data_w-1:0]  byp_data_q;  // held bypass read beat
  logic               bypass;
  logic [addr_w-1:0]  line_addr;

  // address split
  assign arr.tag      = req_addr[addr_w-1 -: tag_w];
  assign arr.index    = req_addr[offset_w +: index_w];
  assign arr.word_sel = req_addr[2 +: word_w];

  assign bypass    = ~|(req_addr & no_cache_mask) || |(req_addr & io_space_mask);
  assign line_addr = {req_addr[addr_w-1:offset_w], {offset_w{1'b0}}};

  // write payloads follow the held request
  assign arr.wr_data     = req_wdata;
  assign arr.wr_strb     = req_wstrb;
  assign arr.refill_data = rd_rsp_data;
  assign arr.refill_last = rd_rsp_last;
  assign wb_word         = req_wdata;
  assign wb_strb         = req_wstrb;

  assign rsp_data = byp_q ? byp_data_q : arr.hit_word;

  always_comb begin
    state_d       = state_q;
    req_ready     = 1'b0;
    rsp_valid     = 1'b0;
    rd_req_valid  = 1'b0;
    rd_req_addr   = line_addr;
    rd_req_len    = line_burst_len;
    rd_rsp_ready  = 1'b0;
    wr_req_valid  = 1'b0;
    wr_req_addr   = {arr.victim_tag, arr.index, {offset_w{1'b0}}};  // evicted line
    wr_req_len    = line_burst_len;
    wb_load       = 1'b0;
    wb_single     = 1'b0;
    arr.wr_hit_en = 1'b0;
    arr.refill_en = 1'b0;
    arr.touch     = 1'b0;
    case (state_q)
      st_idle: begin
        if (req_valid) begin
          if (bypass) state_d = req_wr ? st_byp_wr_req : st_byp_rd_req;
          else if (arr.hit) state_d = req_wr ? st_wr_hit : st_rd_rsp;
          else state_d = st_wb_req;  // victim is ready one cycle later
        end
      end
      st_rd_rsp: begin
        rsp_valid = 1'b1;
        if (rsp_ready) begin
          req_ready = 1'b1;
          arr.touch = !byp_q;
          state_d   = st_idle;
        end
      end
      st_wr_hit: begin
        arr.wr_hit_en = 1'b1;
        arr.touch     = 1'b1;
        req_ready     = 1'b1;
        state_d       = st_idle;
      end
      st_wb_req: begin
        if (!arr.victim_dirty) begin
          state_d = st_rf_req;  // clean victim, straight to refill
        end else begin
          wr_req_valid = 1'b1;
          if (wr_req_ready) begin
            wb_load = 1'b1;
            state_d = st_wb_drain;
          end
        end
      end
      st_wb_drain: if (wb_done) state_d = st_rf_req;
      st_rf_req: begin
        rd_req_valid = 1'b1;
        if (rd_req_ready) state_d = st_refill;
      end
      st_refill: begin
        rd_rsp_ready  = 1'b1;
        arr.refill_en = rd_rsp_valid;
        if (rd_rsp_valid && rd_rsp_last) begin
          state_d = req_wr ? st_wr_hit : st_rd_rsp;  // finish as a hit
        end
      end
      st_byp_rd_req: begin
        rd_req_valid = 1'b1;
        rd_req_addr  = req_addr;
        rd_req_len   = single_burst_len;
        if (rd_req_ready) state_d = st_byp_rd_wait;
      end
      st_byp_rd_wait: begin
        rd_rsp_ready = 1'b1;
        if (rd_rsp_valid && rd_rsp_last) state_d = st_rd_rsp;
      end
      st_byp_wr_req: begin
        wr_req_valid = 1'b1;
        wr_req_addr  = req_addr;
        wr_req_len   = single_burst_len;
        if (wr_req_ready) begin
          wb_single = 1'b1;
          state_d   = st_byp_wr_wait;
        end
      end
      st_byp_wr_wait: begin
        if (wb_done) begin
          req_ready = 1'b1;  // write done once the beat is taken
          state_d   = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
      byp_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == st_idle && req_valid) byp_q <= bypass;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == st_byp_rd_wait && rd_rsp_valid) byp_data_q <= rd_rsp_data;
  end

endmodule

/* src/dcache_wb_buf.sv */
module dcache_wb_buf (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          load,    // whole line, 8 beats
  input  logic [dcache_pkg::line_w-1:0] line,
  input  logic                          single,  // one bypass beat
  input  logic [dcache_pkg::data_w-1:0] word,
  input  logic [dcache_pkg::strb_w-1:0] strb,
  output logic                          wr_data_valid,
  output logic [dcache_pkg::data_w-1:0] wr_data,
  output logic [dcache_pkg::strb_w-1:0] wr_data_strb,
  output logic                          wr_data_last,
  input  logic                          wr_data_ready,
  output logic                          done
);
  import dcache_pkg::*;

  logic [line_w-1:0] shift_q;   // next beat sits in the low word
  logic [strb_w-1:0] strb_q;
  logic              valid_q;
  logic              single_q;
  logic [word_w-1:0] beat_q;

  assign wr_data_valid = valid_q;
  assign wr_data       = shift_q[data_w-1:0];
  assign wr_data_strb  = strb_q;
  assign wr_data_last  = single_q || (beat_q == word_w'(beats_per_line - 1));
  assign done          = valid_q && wr_data_ready && wr_data_last;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q  <= 1'b0;
      single_q <= 1'b0;
      beat_q   <= '0;
    end else if (load) begin
      valid_q  <= 1'b1;
      single_q <= 1'b0;
      beat_q   <= '0;
    end else if (single) begin
      valid_q  <= 1'b1;
      single_q <= 1'b1;
      beat_q   <= '0;
    end else if (valid_q && wr_data_ready) begin
      valid_q <= !wr_data_last;  // drop after the last beat
      beat_q  <= beat_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      shift_q <= line;
      strb_q  <= '1;  // write-back always full words
    end else if (single) begin
      shift_q[data_w-1:0] <= word;
      strb_q              <= strb;
    end else if (valid_q && wr_data_ready) begin
      shift_q <= shift_q >> data_w;
    end
  end

endmodule

/* src/dcache_victim.sv */
module dcache_victim (
  input logic clk,
  input logic rst,
  dcache_array_if.victim arr
);
  import dcache_pkg::*;

  logic [stamp_w-1:0] stamp_q [num_sets][num_ways];  // last use per way
  logic [stamp_w-1:0] ctr_q;                         // global use counter, wraps
  logic [way_w-1:0]   victim_q;

  logic               stamp_en;
  logic [way_w-1:0]   stamp_way;
  logic [way_w-1:0]   sel_way;
  logic [stamp_w-1:0] sel_stamp;
  logic               found_free;

  assign stamp_en  = arr.touch || (arr.refill_en && arr.refill_last);
  assign stamp_way = arr.touch ? arr.hit_way : victim_q;  // refill end stamps the new line

  // oldest stamp wins, a free way beats any stamp, ties to the lower way
  always_comb begin
    sel_way    = '0;
    sel_stamp  = stamp_q[arr.index][0];
    found_free = 1'b0;
    for (int w = 0; w < num_ways; w++) begin
      if (!found_free) begin
        if (!arr.way_valid[w]) begin
          sel_way    = way_w'(w);
          found_free = 1'b1;  // stop, stamps of free ways are meaningless
        end else if (stamp_q[arr.index][w] < sel_stamp) begin
          sel_way   = way_w'(w);
          sel_stamp = stamp_q[arr.index][w];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctr_q    <= '0;
      victim_q <= '0;
    end else begin
      victim_q <= sel_way;  // lags the index by one cycle
      if (stamp_en) begin
        ctr_q <= ctr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (stamp_en) begin
      stamp_q[arr.index][stamp_way] <= ctr_q;
    end
  end

  assign arr.victim_way = victim_q;

endmodule

/* src/dcache_ways.sv */
module dcache_ways (
  input logic clk,
  input logic rst,
  dcache_array_if.ways arr
);
  import dcache_pkg::*;

  logic [num_ways-1:0] valid_q [num_sets];  // per set, one bit per way
  logic [num_ways-1:0] dirty_q [num_sets];
  logic [tag_w-1:0]    tag_q   [num_sets][num_ways];
  logic [line_w-1:0]   data_q  [num_sets][num_ways];

  logic [num_ways-1:0] hit_vec;
  logic [way_w-1:0]    hit_way;
  logic [line_w-1:0]   hit_line;

  // tag compare across all ways of the set
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      hit_vec[w] = valid_q[arr.index][w] && (tag_q[arr.index][w] == arr.tag);
    end
  end

  // lowest matching way wins, only one can match anyway
  always_comb begin
    hit_way = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way = way_w'(w);
      end
    end
  end

  assign hit_line = data_q[arr.index][hit_way];

  assign arr.hit       = |hit_vec;
  assign arr.hit_way   = hit_way;
  assign arr.hit_word  = hit_line[arr.word_sel * data_w +: data_w];  // word of the request
  assign arr.way_valid = valid_q[arr.index];

  // victim view for write-back
  assign arr.victim_dirty = dirty_q[arr.index][arr.victim_way];
  assign arr.victim_tag   = tag_q[arr.index][arr.victim_way];
  assign arr.victim_line  = data_q[arr.index][arr.victim_way];

  // state bits
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < num_sets; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
      end
    end else begin
      if (arr.wr_hit_en) begin
        dirty_q[arr.index][hit_way] <= 1'b1;  // line now differs from memory
      end
      if (arr.refill_en && arr.refill_last) begin
        valid_q[arr.index][arr.victim_way] <= 1'b1;
        dirty_q[arr.index][arr.victim_way] <= 1'b0;  // fresh copy of memory
      end
    end
  end

  // tags and line data
  always_ff @(posedge clk) begin
    if (arr.wr_hit_en) begin
      // byte merge under the strobe
      for (int b = 0; b < strb_w; b++) begin
        if (arr.wr_strb[b]) begin
          data_q[arr.index][hit_way][arr.word_sel * data_w + b * 8 +: 8] <=
            arr.wr_data[b * 8 +: 8];
        end
      end
    end
    if (arr.refill_en) begin
      // beats come lowest word first, shift them in from the top
      data_q[arr.index][arr.victim_way] <=
        {arr.refill_data, data_q[arr.index][arr.victim_way][line_w-1:data_w]};
      if (arr.refill_last) begin
        tag_q[arr.index][arr.victim_way] <= arr.tag;
      end
    end
  end

endmodule

/* src/dcache_array_if.sv */
interface dcache_array_if;
  import dcache_pkg::*;

  // lookup, from ctrl
  logic [index_w-1:0]  index;
  logic [tag_w-1:0]    tag;
  logic [word_w-1:0]   word_sel;        // word slot inside the line

  // lookup result, from ways
  logic                hit;
  logic [way_w-1:0]    hit_way;
  logic [data_w-1:0]   hit_word;
  logic [num_ways-1:0] way_valid;       // valid bits of the indexed set

  // line updates, from ctrl
  logic                wr_hit_en;
  logic [data_w-1:0]   wr_data;
  logic [strb_w-1:0]   wr_strb;
  logic                refill_en;       // one pulse per refill beat
  logic [data_w-1:0]   refill_data;
  logic                refill_last;
  logic                touch;           // hit access completes, restamp hit way

  // replacement
  logic [way_w-1:0]    victim_way;      // from victim
  logic                victim_dirty;    // the rest from ways
  logic [tag_w-1:0]    victim_tag;
  logic [line_w-1:0]   victim_line;

  modport ctrl (
    output index, tag, word_sel, wr_hit_en, wr_data, wr_strb,
    output refill_en, refill_data, refill_last, touch,
    input  hit, hit_way, hit_word, victim_dirty, victim_tag
  );

  modport ways (
    input  index, tag, word_sel, wr_hit_en, wr_data, wr_strb,
    input  refill_en, refill_data, refill_last, victim_way,
    output hit, hit_way, hit_word, way_valid, victim_dirty, victim_tag, victim_line
  );

  modport victim (
    input  index, hit_way, way_valid, touch, refill_en, refill_last,
    output victim_way
  );

endinterface

/* src/dcache_pkg.sv */
package dcache_pkg;

  // bus widths
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;

  // geometry: 8 sets x 6 ways of 32-byte lines
  localparam int num_sets = 8;
  localparam int num_ways = 6;
  localparam int way_w    = $clog2(num_ways);        // 3 bits hold way 0..5
  localparam int index_w  = $clog2(num_sets);
  localparam int offset_w = 5;                       // byte in line
  localparam int word_w   = offset_w - 2;            // word slot in line, also beat number
  localparam int tag_w    = addr_w - index_w - offset_w;
  localparam int line_w   = 8 << offset_w;           // 256 bits
  localparam int beats_per_line = line_w / data_w;

  // memory burst length codes, beats minus one
  localparam int burst_len_w = 8;
  localparam logic [burst_len_w-1:0] line_burst_len   = burst_len_w'(beats_per_line - 1);
  localparam logic [burst_len_w-1:0] single_burst_len = '0;

  localparam int stamp_w = 16;                       // lru last-use stamp, wraps

  // uncached windows: the first line of memory and the io space
  localparam logic [addr_w-1:0] no_cache_mask = 32'hffffffe0;
  localparam logic [addr_w-1:0] io_space_mask = 32'hc0000000;

  // controller states
  localparam int state_w = 4;
  localparam logic [state_w-1:0] st_idle        = 4'd0;
  localparam logic [state_w-1:0] st_rd_rsp      = 4'd1;
  localparam logic [state_w-1:0] st_wr_hit      = 4'd2;
  localparam logic [state_w-1:0] st_wb_req      = 4'd3;
  localparam logic [state_w-1:0] st_wb_drain    = 4'd4;
  localparam logic [state_w-1:0] st_rf_req      = 4'd5;
  localparam logic [state_w-1:0] st_refill      = 4'd6;
  localparam logic [state_w-1:0] st_byp_rd_req  = 4'd7;
  localparam logic [state_w-1:0] st_byp_rd_wait = 4'd8;
  localparam logic [state_w-1:0] st_byp_wr_req  = 4'd9;
  localparam logic [state_w-1:0] st_byp_wr_wait = 4'd10;

endpackage
